// File: project.f
logic/psram_pkg.sv
logic/psram_req_if.sv
logic/psram_bus_port.sv
logic/psram_async_ctrl.sv
logic/psram_data_io.sv
logic/psram_top.sv
bench/psram_model.sv
bench/tb_psram.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then scan the log for the fail message
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal --top-module tb_psram \
        -f project.f -o tb_psram_sim \
    && ./obj_dir/tb_psram_sim | tee sim.log \
    && grep -q "^errors:" sim.log \
    && ! grep -q "CHECKS FAILED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: bench/tb_psram.sv
module tb_psram;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LAT     = 4;
    localparam int TIMEOUT = 200;   // Cycles per access

    logic        clk50MHz;
    logic        rst;
    logic        bus_req;
    logic        bus_we;
    logic [2:0]  bus_burst;
    logic [1:0]  bus_be;
    logic [31:0] bus_wdata;
    logic [31:0] bus_rdata;
    logic        bus_wait;
    logic        bus_valid;
    wire  [15:0] mem_data;
    logic [22:0] maddr;
    logic        mce_L, madv_L, moe_L, mwe_L, mub_L, mlb_L;

    logic [31:0] lfsr = 32'h80d0;
    logic [15:0] shadow [0:1023];  // Expected memory contents
    logic [22:0] base;
    int          data_errors = 0;
    int          proto_errors = 0;

    psram_top #(.RW_LATENCY_CYCLES(LAT)) dut (.*);
    psram_model model (.*);

    initial begin
        clk50MHz = 1'b0;
        forever #10 clk50MHz = ~clk50MHz;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic int burst_len(input logic [2:0] code, input logic we);
        if (we || code > 3'd4) return 1;
        return 1 << code;
    endfunction

    // One host transaction, then bus_req held for hold extra cycles
    task automatic run_access(input logic we, input logic [1:0] be, input logic [2:0] code,
                              input logic [22:0] addr, input logic [15:0] data, input int hold);
        int          cycles;
        int          ce_cycles;
        int          words;
        int          pulses;
        logic [22:0] waddr;
        logic [4:0]  strobes;
        logic [4:0]  strobes_exp;  // madv_L, moe_L, mwe_L, mub_L, mlb_L
        cycles      = 1;
        ce_cycles   = 0;
        words       = 0;
        pulses      = 0;
        strobes_exp = {1'b0, we, !we, we ? ~be : 2'b00};
        @(posedge clk50MHz);
        #2;
        bus_req   = 1'b1;
        bus_we    = we;
        bus_be    = be;
        bus_burst = code;
        bus_wdata = {9'd0, addr};  // Address phase
        @(posedge clk50MHz);
        #2 bus_wdata = {16'd0, data};
        forever begin
            if (!mce_L) begin
                ce_cycles++;
                assert (maddr == addr + 23'(words)) else begin
                    $display("mismatch at %0t: maddr expected %h got %h",
                             $time, addr + 23'(words), maddr);
                    proto_errors++;
                end
                strobes = {madv_L, moe_L, mwe_L, mub_L, mlb_L};
                assert (strobes == strobes_exp) else begin
                    $display("mismatch at %0t: madv_L..mlb_L expected %b got %b",
                             $time, strobes_exp, strobes);
                    proto_errors++;
                end
            end else if (ce_cycles != 0) begin
                assert (ce_cycles == LAT + 1) else begin
                    $display("mce_L was low for %0d cycles at %0t", ce_cycles, $time);
                    proto_errors++;
                end
                ce_cycles = 0;
                words++;
            end
            if (bus_valid) begin
                waddr = addr + 23'(pulses);
                assert (bus_rdata == {16'd0, shadow[waddr[9:0]]}) else begin
                    $display("mismatch at %0t: bus_rdata expected %h got %h",
                             $time, {16'd0, shadow[waddr[9:0]]}, bus_rdata);
                    data_errors++;
                end
                pulses++;
            end
            if (!bus_wait || cycles >= TIMEOUT) break;
            @(posedge clk50MHz);
            #1;
            cycles++;
        end
        if (bus_wait) begin
            $display("timeout at %0t, bus_wait never fell", $time);
            proto_errors++;
        end else begin
            assert (words == burst_len(code, we) && pulses == (we ? 0 : words)) else begin
                $display("burst code %0d gave %0d words and %0d valid pulses",
                         code, words, pulses);
                proto_errors++;
            end
            if (burst_len(code, we) == 1) begin
                assert (cycles == LAT + 2) else begin
                    $display("single access took %0d cycles to drop bus_wait", cycles);
                    proto_errors++;
                end
            end
            repeat (hold + 1) begin
                @(posedge clk50MHz);
                #1;
                assert (!bus_wait && mce_L && !bus_valid) else begin
                    $display("controller active at %0t while bus_req was still held", $time);
                    proto_errors++;
                end
            end
        end
        #1 bus_req = 1'b0;
        if (we && be[0]) shadow[addr[9:0]][7:0] = data[7:0];
        if (we && be[1]) shadow[addr[9:0]][15:8] = data[15:8];
    endtask

    initial begin
        rst       = 1'b1;
        bus_req   = 1'b0;
        bus_we    = 1'b0;
        bus_burst = 3'd0;
        bus_be    = 2'b00;
        bus_wdata = '0;
        repeat (3) @(posedge clk50MHz);
        #2 rst = 1'b0;
        @(posedge clk50MHz);
        #1;
        assert (mce_L && madv_L && moe_L && mwe_L && !bus_wait && !bus_valid
                && mem_data === {16{1'bz}}) else begin
            $display("pins or handshake not idle after reset");
            proto_errors++;
        end
        base = 23'(rand_bits(23));
        // Writes ignore the burst code
        for (int i = 0; i < 20; i++) begin
            run_access(1'b1, 2'b11, 3'(i % 8), base + 23'(i), 16'(rand_bits(16)), i % 3);
        end
        run_access(1'b0, 2'b00, 3'd0, base, 16'd0, 0);
        // Single lane writes keep the other byte
        run_access(1'b1, 2'b01, 3'd0, base + 23'd1, 16'(rand_bits(16)), 0);
        run_access(1'b1, 2'b10, 3'd0, base + 23'd2, 16'(rand_bits(16)), 2);
        run_access(1'b0, 2'b00, 3'd0, base + 23'd1, 16'd0, 0);
        run_access(1'b0, 2'b00, 3'd0, base + 23'd2, 16'd0, 1);
        for (int c = 0; c < 8; c++) begin
            run_access(1'b0, 2'b00, 3'(c), base + 23'(c), 16'd0, c % 2);  // 5 to 7 read one word
        end
        repeat (4) @(posedge clk50MHz);
        $display("errors: data %0d, protocol %0d, model timing %0d",
                 data_errors, proto_errors, model.timing_errors);
        if (data_errors + proto_errors + model.timing_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: bench/psram_model.sv
module psram_model #(
    parameter int A_WIDTH = 23,
    parameter int D_WIDTH = 16
) (
    inout  wire  [D_WIDTH-1:0] mem_data,
    input  logic [A_WIDTH-1:0] maddr,
    input  logic               mce_L,
    input  logic               madv_L,
    input  logic               moe_L,
    input  logic               mwe_L,
    input  logic               mub_L,
    input  logic               mlb_L
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam real T_ACCESS_NS = 70.0;

    logic [D_WIDTH-1:0] mem [0:1023];
    wire  [D_WIDTH-1:0] data_dly;      // Pins as they were 1 ns earlier
    realtime            ce_fall = 0.0;
    realtime            addr_chg;
    logic               ce_seen = 1'b0;
    int                 timing_errors = 0;

    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 16'(i * 40503) ^ 16'h3c5a;  // Pattern spans the whole index
        end
    end

    // Async read with the address flowing through while madv_L is low
    assign mem_data = (!mce_L && !madv_L && !moe_L && mwe_L) ? mem[maddr[9:0]]
                                                             : {D_WIDTH{1'bz}};

    // Write data is held well before mwe_L rises
    assign #1 data_dly = mem_data;

    always @(posedge mwe_L) begin
        if (!mlb_L) mem[maddr[9:0]][7:0] <= data_dly[7:0];
        if (!mub_L) mem[maddr[9:0]][15:8] <= data_dly[15:8];
    end

    always @(negedge mce_L) begin
        ce_fall = $realtime;
        ce_seen = 1'b1;
    end

    always @(posedge mce_L) begin
        if (ce_seen) begin
            assert ($realtime - ce_fall >= T_ACCESS_NS) else begin
                $display("access at %0t lasted only %0.1f ns", $time, $realtime - ce_fall);
                timing_errors++;
            end
        end
    end

    // A change in the same step as the chip select edge is allowed
    always @(maddr) begin
        addr_chg = $realtime;
        #0.1;
        assert (!ce_seen || mce_L || ce_fall >= addr_chg) else begin
            $display("maddr changed at %0.1f ns while mce_L was low", addr_chg);
            timing_errors++;
        end
    end

endmodule

// File: logic/psram_top.sv
module psram_top #(
    parameter int A_WIDTH           = 23,
    parameter int D_WIDTH           = 16,
    parameter int BUS_WIDTH         = 32,
    parameter int RW_LATENCY_CYCLES = 4   // 80 ns at 50 MHz
) (
    input  logic                 clk50MHz,
    input  logic                 rst,
    // Host bus
    input  logic                 bus_req,
    input  logic                 bus_we,
    input  logic [2:0]           bus_burst,
    input  logic [1:0]           bus_be,
    input  logic [BUS_WIDTH-1:0] bus_wdata,
    output logic [BUS_WIDTH-1:0] bus_rdata,
    output logic                 bus_wait,
    output logic                 bus_valid,
    // PSRAM pins
    inout  wire  [D_WIDTH-1:0]   mem_data,
    output logic [A_WIDTH-1:0]   maddr,
    output logic                 mce_L,
    output logic                 madv_L,
    output logic                 moe_L,
    output logic                 mwe_L,
    output logic                 mub_L,
    output logic                 mlb_L
);
    import psram_pkg::*;

    logic drive;
    logic capture;
    logic load_wdata;

    psram_req_if #(.A_WIDTH(A_WIDTH)) req ();

    psram_bus_port #(
        .A_WIDTH   (A_WIDTH),
        .BUS_WIDTH (BUS_WIDTH)
    ) u_bus_port (
        .clk50MHz  (clk50MHz),
        .rst       (rst),
        .bus_req   (bus_req),
        .bus_we    (bus_we),
        .bus_burst (burst_code_e'(bus_burst)),
        .bus_be    (bus_be),
        .bus_wdata (bus_wdata),
        .req       (req.port)
    );

    psram_async_ctrl #(
        .RW_LATENCY_CYCLES (RW_LATENCY_CYCLES)
    ) u_async_ctrl (
        .clk50MHz   (clk50MHz),
        .rst        (rst),
        .bus_req    (bus_req),
        .req        (req.seq),
        .mce_L      (mce_L),
        .madv_L     (madv_L),
        .moe_L      (moe_L),
        .mwe_L      (mwe_L),
        .bus_wait   (bus_wait),
        .drive      (drive),
        .capture    (capture),
        .load_wdata (load_wdata)
    );

    psram_data_io #(
        .D_WIDTH   (D_WIDTH),
        .BUS_WIDTH (BUS_WIDTH)
    ) u_data_io (
        .clk50MHz   (clk50MHz),
        .rst        (rst),
        .bus_wdata  (bus_wdata),
        .bus_rdata  (bus_rdata),
        .bus_valid  (bus_valid),
        .drive      (drive),
        .capture    (capture),
        .load_wdata (load_wdata),
        .mem_data   (mem_data)
    );

    assign maddr = req.addr;

    // Reads always use both lanes
    assign mub_L = req.we && !req.be[1];
    assign mlb_L = req.we && !req.be[0];

endmodule

// File: logic/psram_data_io.sv
module psram_data_io #(
    parameter int D_WIDTH   = 16,
    parameter int BUS_WIDTH = 32
) (
    input  logic                 clk50MHz,
    input  logic                 rst,
    input  logic [BUS_WIDTH-1:0] bus_wdata,
    output logic [BUS_WIDTH-1:0] bus_rdata,
    output logic                 bus_valid,
    input  logic                 drive,
    input  logic                 capture,
    input  logic                 load_wdata,
    inout  wire  [D_WIDTH-1:0]   mem_data
);

    logic [D_WIDTH-1:0] wdata_q;  // Word being written
    logic [D_WIDTH-1:0] rdata_q;  // Last word read

    // Host presents write data one cycle after the request
    always_ff @(posedge clk50MHz) begin
        if (load_wdata) begin
            wdata_q <= bus_wdata[D_WIDTH-1:0];
        end
    end

    // Pins released unless a write is in progress
    assign mem_data = drive ? wdata_q : {D_WIDTH{1'bz}};

    always_ff @(posedge clk50MHz) begin
        if (capture) begin
            rdata_q <= mem_data;  // Sampled at the end of DATA
        end
    end

    always_ff @(posedge clk50MHz) begin
        if (rst) begin
            bus_valid <= 1'b0;
        end else begin
            bus_valid <= capture;  // One cycle per read word
        end
    end

    assign bus_rdata = {{(BUS_WIDTH - D_WIDTH){1'b0}}, rdata_q};

endmodule

// File: logic/psram_async_ctrl.sv
module psram_async_ctrl #(
    parameter int RW_LATENCY_CYCLES = 4
) (
    input  logic     clk50MHz,
    input  logic     rst,
    input  logic     bus_req,
    psram_req_if.seq req,
    output logic     mce_L,
    output logic     madv_L,
    output logic     moe_L,
    output logic     mwe_L,
    output logic     bus_wait,
    output logic     drive,
    output logic     capture,
    output logic     load_wdata
);
    import psram_pkg::*;

    localparam int LAT_W = (RW_LATENCY_CYCLES > 1) ? $clog2(RW_LATENCY_CYCLES) : 1;

    ctrl_state_e      state;
    ctrl_state_e      state_next;
    logic [LAT_W-1:0] lat_cnt;     // Cycles spent in ACCESS
    logic             lat_done;
    logic             in_word;     // Chip selected for the current word

    assign lat_done = (lat_cnt == LAT_W'(RW_LATENCY_CYCLES - 1));

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (bus_req) begin
                    state_next = ACCESS;  // Same cycle the bus port latches
                end
            end
            ACCESS: begin
                if (lat_done) begin
                    state_next = DATA;
                end
            end
            DATA: begin
                if (req.last) begin
                    state_next = FINISH;
                end else begin
                    state_next = NEXT;
                end
            end
            NEXT: begin
                state_next = ACCESS;
            end
            FINISH: begin
                if (!bus_req) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk50MHz) begin
        if (rst) begin
            state   <= IDLE;
            lat_cnt <= '0;
        end else begin
            state <= state_next;
            if (state == ACCESS && !lat_done) begin
                lat_cnt <= lat_cnt + 1'b1;
            end else begin
                lat_cnt <= '0;  // Restart for every word
            end
        end
    end

    assign in_word = (state == ACCESS) || (state == DATA);

    // Pin strobes, all active low
    assign mce_L  = !in_word;
    assign madv_L = !in_word;                // Address flows through while low
    assign moe_L  = !(in_word && !req.we);
    assign mwe_L  = !(in_word && req.we);    // Rising edge commits the write

    assign bus_wait = in_word || (state == NEXT);

    // Data path controls
    assign drive      = in_word && req.we;
    assign capture    = (state == DATA) && !req.we;
    assign load_wdata = (state == ACCESS) && (lat_cnt == '0) && req.we;

    // Address steps as the chip deselects for NEXT
    assign req.advance = (state == DATA) && !req.last;
    assign req.done    = (state == DATA) && req.last;

endmodule

// File: logic/psram_bus_port.sv
module psram_bus_port #(
    parameter int A_WIDTH   = 23,
    parameter int BUS_WIDTH = 32
) (
    input  logic                   clk50MHz,
    input  logic                   rst,
    input  logic                   bus_req,
    input  logic                   bus_we,
    input  psram_pkg::burst_code_e bus_burst,
    input  logic [1:0]             bus_be,
    input  logic [BUS_WIDTH-1:0]   bus_wdata,
    psram_req_if.port              req
);
    import psram_pkg::*;

    logic                  req_seen;     // This bus_req was already taken
    logic                  take;
    logic [WORD_CNT_W-1:0] burst_words;
    logic [WORD_CNT_W-1:0] words_left;   // Includes the current word

    // Host keeps bus_req high through FINISH, so only a fresh request counts
    assign take = bus_req && !req.active && !req_seen;

    // Burst length in words
    always_comb begin
        case (bus_burst)
            BURST_2:  burst_words = WORD_CNT_W'(2);
            BURST_4:  burst_words = WORD_CNT_W'(4);
            BURST_8:  burst_words = WORD_CNT_W'(8);
            BURST_16: burst_words = WORD_CNT_W'(MAX_BURST_WORDS);
            default:  burst_words = WORD_CNT_W'(1);
        endcase
        if (bus_we) begin
            burst_words = WORD_CNT_W'(1);  // Writes are single words
        end
    end

    always_ff @(posedge clk50MHz) begin
        if (rst) begin
            req.active <= 1'b0;
            req.we     <= 1'b0;
            req.last   <= 1'b0;
            req_seen   <= 1'b0;
            words_left <= '0;
        end else begin
            if (take) begin
                req.active <= 1'b1;
                req.we     <= bus_we;
            end else if (req.done) begin
                req.active <= 1'b0;
            end

            if (!bus_req) begin
                req_seen <= 1'b0;
            end else if (take) begin
                req_seen <= 1'b1;
            end

            if (take) begin
                words_left <= burst_words;
                req.last   <= (burst_words == WORD_CNT_W'(1));
            end else if (req.advance) begin
                words_left <= words_left - 1'b1;
                req.last   <= (words_left == WORD_CNT_W'(2));  // One left after this step
            end
        end
    end

    // Address arrives on the data lines in the request cycle
    always_ff @(posedge clk50MHz) begin
        if (take) begin
            req.addr <= bus_wdata[A_WIDTH-1:0];
            req.be   <= bus_be;
        end else if (req.advance) begin
            req.addr <= req.addr + 1'b1;
        end
    end

endmodule

// File: logic/psram_req_if.sv
interface psram_req_if #(
    parameter int A_WIDTH = 23
);

    logic               active;   // Request taken, not yet done
    logic               we;       // Write access
    logic [A_WIDTH-1:0] addr;     // Address of the current word
    logic [1:0]         be;       // Byte enables, bit 1 is the upper lane
    logic               last;     // Current word is the final one
    logic               advance;  // Move on to the next burst word
    logic               done;     // Sequencer is entering FINISH

    // Bus side owns the latched request
    modport port (
        output active, we, addr, be, last,
        input  advance, done
    );

    // Sequencer side only steps through the words
    modport seq (
        input  active, we, addr, be, last,
        output advance, done
    );

endinterface

// File: logic/psram_pkg.sv
package psram_pkg;

    // Access sequencer states
    typedef enum logic [2:0] {
        IDLE,    // Waiting for bus_req
        ACCESS,  // Chip enabled, latency running
        DATA,    // Last cycle of a word
        NEXT,    // Gap between burst words
        FINISH   // Waiting for bus_req to drop
    } ctrl_state_e;

    // Host burst codes
    // 5 to 7 are not listed and decode as a single word
    typedef enum logic [2:0] {
        BURST_1  = 3'd0,
        BURST_2  = 3'd1,
        BURST_4  = 3'd2,
        BURST_8  = 3'd3,
        BURST_16 = 3'd4
    } burst_code_e;

    // Longest read burst in words
    localparam int MAX_BURST_WORDS = 16;

    // Word counter must hold MAX_BURST_WORDS itself
    localparam int WORD_CNT_W = $clog2(MAX_BURST_WORDS) + 1;

endpackage
